// File: hdl/ac97_pkg.sv
package ac97_pkg;

  //////////////////////////////////////////////////////////////////////
  // frame geometry
  //////////////////////////////////////////////////////////////////////

  // one AC97 frame is 256 bit clocks
  localparam int frame_bits = 256;

  // position within the frame
  typedef logic [7:0] bit_count_t;

  // sync covers the tag slot, counts 0 to 15
  localparam bit_count_t sync_last_bit = 8'd15;

  // transmit slot boundaries, first bit of each slot
  localparam bit_count_t slot1_first = 8'd16;
  localparam bit_count_t slot2_first = 8'd36;
  localparam bit_count_t slot3_first = 8'd56;
  localparam bit_count_t slot4_first = 8'd76;
  localparam bit_count_t slot4_last  = 8'd95;

  // data slots are 20 bits wide
  localparam int slot_bits = 20;

  // receive side samples one bit clock behind transmit
  localparam int rx_lag = 1;

  //////////////////////////////////////////////////////////////////////
  // data types
  //////////////////////////////////////////////////////////////////////

  // full slot word, msb first on the wire
  typedef logic [slot_bits-1:0] sample_t;

  // user sample, sits in the top 8 bits of a slot
  typedef logic [7:0] pcm8_t;

  // 31 is loudest
  typedef logic [4:0] volume_t;

  // codec register command, 25 bits
  typedef struct packed {
    logic        valid;
    logic [7:0]  address;
    logic [15:0] data;
  } ac97_cmd_t;

  // one sequencer step per frame, wraps after 16
  typedef enum logic [3:0] {
    st_read_id0, st_read_id1, st_idle_2, st_headphone,
    st_idle_4, st_pcm_vol, st_rec_select, st_rec_gain,
    st_idle_8, st_mic_gain, st_beep, st_general,
    st_idle_c, st_idle_d, st_idle_e, st_idle_f
  } cmd_state_e;

  // codec register addresses used by the sequencer
  typedef enum logic [7:0] {
    reg_headphone  = 8'h04,
    reg_beep       = 8'h0A,
    reg_mic_vol    = 8'h0E,
    reg_pcm_vol    = 8'h18,
    reg_rec_select = 8'h1A,
    reg_rec_gain   = 8'h1C,
    reg_general    = 8'h20,
    reg_read_id    = 8'h80
  } ac97_reg_e;

endpackage

// File: hdl/ac97_frame_timer.sv
`timescale 1ns/1ps

module ac97_frame_timer
  import ac97_pkg::*;
#(
  parameter int RESET_HOLD = 1023
) (
  input  logic       clock,
  input  logic       reset,
  output logic       codec_reset_n,
  output logic       running,
  output bit_count_t bit_count,
  output logic       frame_end,
  output logic       sync
);

  localparam int hold_w = $clog2(RESET_HOLD + 1);
  localparam bit_count_t last_bit = bit_count_t'(frame_bits - 1);

  logic [hold_w-1:0] hold_count;

  //////////////////////////////////////////////////////////////////////
  // codec reset hold
  //////////////////////////////////////////////////////////////////////

  // count hold cycles, then release the codec for good
  always_ff @(posedge clock) begin
    if (reset) begin
      hold_count <= '0;
      running    <= 1'b0;
    end else if (!running) begin
      if (hold_count == hold_w'(RESET_HOLD - 1)) begin
        running <= 1'b1;
      end
      hold_count <= hold_count + 1'b1;
    end
  end

  // codec comes out of reset together with the frame counter
  assign codec_reset_n = running;

  //////////////////////////////////////////////////////////////////////
  // bit counter and sync
  //////////////////////////////////////////////////////////////////////

  // free running, wraps at 256, parked at 0 until released
  always_ff @(posedge clock) begin
    if (reset) begin
      bit_count <= '0;
    end else if (running) begin
      bit_count <= bit_count + 1'b1;
    end
  end

  assign frame_end = running && (bit_count == last_bit);

  // set on the last bit so sync covers counts 0..15 of the next frame
  // first frame after release has no sync
  always_ff @(posedge clock) begin
    if (reset) begin
      sync <= 1'b0;
    end else if (frame_end) begin
      sync <= 1'b1;
    end else if (bit_count == sync_last_bit) begin
      sync <= 1'b0;
    end
  end

endmodule

// File: hdl/ac97_frame_tx.sv
`timescale 1ns/1ps

module ac97_frame_tx
  import ac97_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  bit_count_t bit_count,
  input  logic       frame_end,
  input  ac97_cmd_t  cmd,
  input  pcm8_t      play_sample,
  output logic       sdata_out
);

  // frame contents latched at the end of the previous frame
  ac97_cmd_t l_cmd;
  sample_t   l_sample;
  logic      l_frame_valid;
  logic      l_audio_valid;
  sample_t   addr_word;
  sample_t   data_word;
  logic      next_bit;

  // pick one bit of a slot word, msb at the slot's first count
  function automatic logic slot_bit(sample_t word, bit_count_t first, bit_count_t count);
    bit_count_t offset;
    offset = count - first;
    return word[slot_bits - 1 - offset];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // frame latch
  //////////////////////////////////////////////////////////////////////

  // valid flags start clear so the first frame goes out empty
  always_ff @(posedge clock) begin
    if (reset) begin
      l_frame_valid <= 1'b0;
      l_audio_valid <= 1'b0;
      l_cmd.valid   <= 1'b0;
    end else if (frame_end) begin
      l_frame_valid <= 1'b1;
      l_audio_valid <= 1'b1;
      l_cmd.valid   <= cmd.valid;
    end
  end

  // payload, left justified sample, same word for both channels
  always_ff @(posedge clock) begin
    if (frame_end) begin
      l_cmd.address <= cmd.address;
      l_cmd.data    <= cmd.data;
      l_sample      <= {play_sample, {(slot_bits - 8){1'b0}}};
    end
  end

  // address in the top 8 bits of slot 1, data in the top 16 of slot 2
  assign addr_word = {l_cmd.address, {(slot_bits - 8){1'b0}}};
  assign data_word = {l_cmd.data, {(slot_bits - 16){1'b0}}};

  //////////////////////////////////////////////////////////////////////
  // serializer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    next_bit = 1'b0;
    if (bit_count <= sync_last_bit) begin
      // tag slot
      case (bit_count[3:0])
        4'd0:    next_bit = l_frame_valid;
        4'd1:    next_bit = l_cmd.valid;
        4'd2:    next_bit = l_cmd.valid;
        4'd3:    next_bit = l_audio_valid;
        4'd4:    next_bit = l_audio_valid;
        default: next_bit = 1'b0;
      endcase
    end else if (bit_count < slot2_first) begin
      next_bit = l_cmd.valid && slot_bit(addr_word, slot1_first, bit_count);
    end else if (bit_count < slot3_first) begin
      next_bit = l_cmd.valid && slot_bit(data_word, slot2_first, bit_count);
    end else if (bit_count < slot4_first) begin
      next_bit = l_audio_valid && slot_bit(l_sample, slot3_first, bit_count);
    end else if (bit_count <= slot4_last) begin
      next_bit = l_audio_valid && slot_bit(l_sample, slot4_first, bit_count);
    end
  end

  // bit for count p shows up on the pin during count p+1
  always_ff @(posedge clock) begin
    if (reset) begin
      sdata_out <= 1'b0;
    end else begin
      sdata_out <= next_bit;
    end
  end

endmodule

// File: hdl/ac97_frame_rx.sv
`timescale 1ns/1ps

module ac97_frame_rx
  import ac97_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  bit_count_t bit_count,
  input  logic       sdata_in,
  output sample_t    rec_left,
  output sample_t    rec_right,
  output logic       rec_valid
);

  // capture windows, one count behind the transmit slots
  localparam bit_count_t left_first  = bit_count_t'(slot3_first + rx_lag);
  localparam bit_count_t right_first = bit_count_t'(slot4_first + rx_lag);
  localparam bit_count_t right_last  = bit_count_t'(slot4_last + rx_lag);

  sample_t left_shift;
  sample_t right_shift;
  logic    in_left;
  logic    in_right;
  logic    word_done;

  assign in_left   = (bit_count >= left_first) && (bit_count < right_first);
  assign in_right  = (bit_count >= right_first) && (bit_count <= right_last);
  assign word_done = (bit_count == right_last);

  // msb arrives first
  always_ff @(posedge clock) begin
    if (in_left) begin
      left_shift <= {left_shift[slot_bits-2:0], sdata_in};
    end
    if (in_right) begin
      right_shift <= {right_shift[slot_bits-2:0], sdata_in};
    end
  end

  // last right bit goes straight into the hold register
  always_ff @(posedge clock) begin
    if (word_done) begin
      rec_left  <= left_shift;
      rec_right <= {right_shift[slot_bits-2:0], sdata_in};
    end
  end

  // one cycle pulse, high during count 97
  always_ff @(posedge clock) begin
    if (reset) begin
      rec_valid <= 1'b0;
    end else begin
      rec_valid <= word_done;
    end
  end

endmodule

// File: hdl/ac97_cmd_sequencer.sv
`timescale 1ns/1ps

module ac97_cmd_sequencer
  import ac97_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      frame_end,
  input  volume_t   volume,
  output ac97_cmd_t cmd
);

  cmd_state_e state;
  ac97_cmd_t  next_cmd;
  volume_t    atten;

  //////////////////////////////////////////////////////////////////////
  // step counter
  //////////////////////////////////////////////////////////////////////

  // one step per frame, 4 bit enum wraps back to st_read_id0
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_read_id0;
    end else if (frame_end) begin
      state <= cmd_state_e'(state + 4'd1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // command decode
  //////////////////////////////////////////////////////////////////////

  // codec wants attenuation, user gives loudness
  assign atten = 5'd31 - volume;

  always_comb begin
    // unused steps poll the vendor id register
    next_cmd.valid   = 1'b1;
    next_cmd.address = reg_read_id;
    next_cmd.data    = 16'h0000;
    case (state)
      st_headphone: begin
        // same attenuation on both channels
        next_cmd.address = reg_headphone;
        next_cmd.data    = {3'b000, atten, 3'b000, atten};
      end
      st_pcm_vol: begin
        next_cmd.address = reg_pcm_vol;
        next_cmd.data    = 16'h0808;
      end
      st_rec_select: begin
        // mic on both record channels
        next_cmd.address = reg_rec_select;
        next_cmd.data    = 16'h0000;
      end
      st_rec_gain: begin
        // max record gain
        next_cmd.address = reg_rec_gain;
        next_cmd.data    = 16'h0F0F;
      end
      st_mic_gain: begin
        // +20dB boost
        next_cmd.address = reg_mic_vol;
        next_cmd.data    = 16'h8048;
      end
      st_beep: begin
        next_cmd.address = reg_beep;
        next_cmd.data    = 16'h0000;
      end
      st_general: begin
        // pcm out bypasses mix1
        next_cmd.address = reg_general;
        next_cmd.data    = 16'h8000;
      end
      default: begin
        // read id and idle steps keep the id poll
      end
    endcase
  end

  // registered one cycle behind the state
  always_ff @(posedge clock) begin
    if (reset) begin
      cmd.valid <= 1'b0;
    end else begin
      cmd <= next_cmd;
    end
  end

endmodule

// File: hdl/ac97_codec_link.sv
`timescale 1ns/1ps

module ac97_codec_link
  import ac97_pkg::*;
#(
  parameter int RESET_HOLD = 1023
) (
  input  logic    clock,
  input  logic    reset,
  input  volume_t volume,
  input  pcm8_t   play_sample,
  input  logic    sdata_in,
  output logic    codec_reset_n,
  output logic    sync,
  output logic    sdata_out,
  output logic    frame_ready,
  output sample_t rec_left,
  output sample_t rec_right,
  output logic    rec_valid
);

  bit_count_t bit_count;
  logic       frame_end;
  ac97_cmd_t  cmd;

  //////////////////////////////////////////////////////////////////////
  // frame timing
  //////////////////////////////////////////////////////////////////////

  // codec reset, bit position and frame strobe
  ac97_frame_timer #(
    .RESET_HOLD(RESET_HOLD)
  ) timer_i (
    .clock        (clock),
    .reset        (reset),
    .codec_reset_n(codec_reset_n),
    .running      (),
    .bit_count    (bit_count),
    .frame_end    (frame_end),
    .sync         (sync)
  );

  // user strobe, sample must be valid in this cycle
  assign frame_ready = frame_end;

  //////////////////////////////////////////////////////////////////////
  // data path
  //////////////////////////////////////////////////////////////////////

  ac97_cmd_sequencer seq_i (
    .clock    (clock),
    .reset    (reset),
    .frame_end(frame_end),
    .volume   (volume),
    .cmd      (cmd)
  );

  ac97_frame_tx tx_i (
    .clock      (clock),
    .reset      (reset),
    .bit_count  (bit_count),
    .frame_end  (frame_end),
    .cmd        (cmd),
    .play_sample(play_sample),
    .sdata_out  (sdata_out)
  );

  ac97_frame_rx rx_i (
    .clock    (clock),
    .reset    (reset),
    .bit_count(bit_count),
    .sdata_in (sdata_in),
    .rec_left (rec_left),
    .rec_right(rec_right),
    .rec_valid(rec_valid)
  );

endmodule

// File: sim/ac97_link_assertions.sv
`timescale 1ns/1ps

module ac97_link_assertions
  import ac97_pkg::*;
(
  input logic       clock,
  input logic       reset,
  input bit_count_t bit_count,
  input logic       sync,
  input logic       frame_ready,
  input logic       codec_reset_n,
  input logic       rec_valid
);

  // number of failed properties so far
  int fail_count;

  initial begin
    fail_count = 0;
  end

  //////////////////////////////////////////////////////////////////////
  // frame timing rules
  //////////////////////////////////////////////////////////////////////

  // sync only covers the tag slot
  sync_in_tag: assert property (
    @(posedge clock) disable iff (reset) sync |-> (bit_count <= sync_last_bit)
  ) else begin
    fail_count++;
    $error("sync high outside the tag slot");
  end

  // the strobe is followed by count 0 of a new frame with sync high
  ready_starts_frame: assert property (
    @(posedge clock) disable iff (reset) frame_ready |=> (sync && (bit_count == '0))
  ) else begin
    fail_count++;
    $error("frame_ready not followed by the start of a frame");
  end

  // no record data while the codec is held in reset
  no_rec_in_reset: assert property (
    @(posedge clock) disable iff (reset) !(rec_valid && !codec_reset_n)
  ) else begin
    fail_count++;
    $error("rec_valid while codec reset is low");
  end

endmodule

// File: sim/ac97_codec_link_tb.sv
`timescale 1ns/1ps

module ac97_codec_link_tb
  import ac97_pkg::*;
();

  localparam int reset_hold = 16;
  localparam int reset_cycles = 10;
  localparam bit_count_t last_count = bit_count_t'(frame_bits - 1);
  // rec_valid is high one count after the last captured bit
  localparam int rec_valid_count = slot4_last + rx_lag + 1;

  logic    clock;
  logic    reset;
  volume_t volume;
  pcm8_t   play_sample;
  logic    sdata_in;
  logic    codec_reset_n;
  logic    sync;
  logic    sdata_out;
  logic    frame_ready;
  sample_t rec_left;
  sample_t rec_right;
  logic    rec_valid;

  // pattern file contents
  volume_t     vols[$];
  pcm8_t       samples[$];
  logic [7:0]  exp_addr[$];
  logic [15:0] exp_data[$];

  // frame tracking, derived from the codec reset release
  logic              linked;
  bit_count_t        count;
  int                frame_idx;
  int                sample_idx;
  logic [0:slot4_last] fbits;
  pcm8_t             latched_sample;
  volume_t           latched_vol;
  pcm8_t             loop_q[$];
  int                writes_seen;
  logic [15:0]       last_hp_data;

  // serial loopback
  assign sdata_in = sdata_out;

  ac97_codec_link #(
    .RESET_HOLD(reset_hold)
  ) dut_i (
    .clock        (clock),
    .reset        (reset),
    .volume       (volume),
    .play_sample  (play_sample),
    .sdata_in     (sdata_in),
    .codec_reset_n(codec_reset_n),
    .sync         (sync),
    .sdata_out    (sdata_out),
    .frame_ready  (frame_ready),
    .rec_left     (rec_left),
    .rec_right    (rec_right),
    .rec_valid    (rec_valid)
  );

  bind ac97_codec_link ac97_link_assertions assert_i (
    .clock        (clock),
    .reset        (reset),
    .bit_count    (bit_count),
    .sync         (sync),
    .frame_ready  (frame_ready),
    .codec_reset_n(codec_reset_n),
    .rec_valid    (rec_valid)
  );

  // 100 ns bit clock
  initial begin
    clock = 1'b0;
    forever begin
      #50 clock = ~clock;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
    if (got !== expected) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, expected);
      $display("Checks failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic abort_run(string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  // attenuation is 31 minus volume, repeated in both bytes
  function automatic logic [15:0] headphone_word(volume_t v);
    int att;
    att = 31 - int'(v);
    return 16'(att * 257);
  endfunction

  // keyword per line: vol, smp, cmd; anything else is a comment
  task automatic load_patterns();
    int          fd;
    int          n;
    string       key;
    string       rest;
    logic [15:0] a;
    logic [15:0] d;
    fd = $fopen("sim/ac97_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open pattern file sim/ac97_patterns.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", key);
        if (n != 1) begin
          break;
        end
        if (key == "vol") begin
          n = $fscanf(fd, "%h", a);
          vols.push_back(volume_t'(a));
        end else if (key == "smp") begin
          n = $fscanf(fd, "%h", a);
          samples.push_back(pcm8_t'(a));
        end else if (key == "cmd") begin
          n = $fscanf(fd, "%h %h", a, d);
          exp_addr.push_back(a[7:0]);
          exp_data.push_back(d);
        end else begin
          n = $fgets(rest, fd);
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // frame decode and per cycle checks
  //////////////////////////////////////////////////////////////////////

  // whole frame received up to slot 4, check tag and slot contents
  task automatic decode_frame();
    logic [4:0]  tags;
    logic [7:0]  addr;
    logic [15:0] data;
    logic [15:0] want;
    sample_t     left;
    sample_t     right;
    sample_t     word;
    int          idx;
    tags  = fbits[0 +: 5];
    addr  = fbits[slot1_first +: 8];
    data  = fbits[slot2_first +: 16];
    left  = fbits[slot3_first +: slot_bits];
    right = fbits[slot4_first +: slot_bits];
    check_value("sdata_out tag spare bits", fbits[5 +: 11], 0);
    // padding below the address and the data
    check_value("sdata_out slot 1 low bits", fbits[slot1_first + 8 +: 12], 0);
    check_value("sdata_out slot 2 low bits", fbits[slot2_first + 16 +: 4], 0);
    if (frame_idx == 0) begin
      // nothing latched yet, first frame goes out empty
      check_value("sdata_out first frame tags", tags, 0);
      check_value("sdata_out first frame slot 1", addr, 0);
      check_value("sdata_out first frame slot 2", data, 0);
      check_value("sdata_out first frame slot 3", left, 0);
      check_value("sdata_out first frame slot 4", right, 0);
    end else begin
      // frame, address, data, left and right all valid
      check_value("sdata_out tags", tags, 5'b11111);
      word = sample_t'({latched_sample, 12'h000});
      check_value("sdata_out slot 3", left, word);
      check_value("sdata_out slot 4", right, word);
      if (addr != reg_read_id) begin
        idx = writes_seen % exp_addr.size();
        check_value("sdata_out slot 1 address", addr, exp_addr[idx]);
        if (exp_addr[idx] == reg_headphone) begin
          want = headphone_word(latched_vol);
          last_hp_data = data;
        end else begin
          want = exp_data[idx];
        end
        check_value("sdata_out slot 2 data", data, want);
        writes_seen++;
      end
    end
  endtask

  task automatic track_frame();
    bit_count_t pos;
    sample_t    word;
    check_value("codec_reset_n", codec_reset_n, 1);
    check_value("frame_ready", frame_ready, count == last_count);
    check_value("sync", sync, (frame_idx > 0) && (count <= sync_last_bit));
    check_value("rec_valid", rec_valid, count == rec_valid_count);
    // pin carries the bit of the previous count
    pos = count - 1'b1;
    if (pos <= slot4_last) begin
      fbits[pos] = sdata_out;
    end else begin
      check_value("sdata_out idle slots", sdata_out, 0);
    end
    if (pos == slot4_last) begin
      decode_frame();
    end
    if (rec_valid) begin
      if (frame_idx == 0) begin
        word = '0;
      end else begin
        word = sample_t'({loop_q.pop_front(), 12'h000});
      end
      check_value("rec_left", rec_left, word);
      check_value("rec_right", rec_right, word);
    end
    if (frame_ready) begin
      latched_sample = play_sample;
      latched_vol    = volume;
      loop_q.push_back(play_sample);
    end
    // new sample at the start of each frame, stable through frame_ready
    if (count == 0) begin
      play_sample = samples[sample_idx % samples.size()];
      sample_idx++;
    end
  endtask

  // one bit clock, sample and drive on the falling edge
  task automatic tick();
    @(negedge clock);
    if (!linked && codec_reset_n === 1'b1) begin
      linked    = 1'b1;
      count     = '0;
      frame_idx = 0;
    end else if (linked) begin
      count = count + 1'b1;
      if (count == 0) begin
        frame_idx++;
      end
    end
    if (!linked) begin
      check_value("sync", sync, 0);
      check_value("sdata_out", sdata_out, 0);
      check_value("frame_ready", frame_ready, 0);
      check_value("rec_valid", rec_valid, 0);
    end else begin
      track_frame();
    end
    // bound frame timing properties
    if (dut_i.assert_i.fail_count != 0) begin
      abort_run("a frame timing assertion failed");
    end
  endtask

  task automatic wait_link(int limit);
    int n;
    n = 0;
    while (!linked) begin
      if (n == limit) begin
        abort_run("timeout waiting for codec_reset_n to rise");
      end else begin
        tick();
        n++;
      end
    end
  endtask

  task automatic wait_writes(int target, int limit);
    int n;
    n = 0;
    while (writes_seen < target) begin
      if (n == limit) begin
        abort_run("timeout waiting for codec register writes");
      end else begin
        tick();
        n++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    reset       = 1'b1;
    volume      = '0;
    play_sample = '0;
    linked      = 1'b0;
    count       = '0;
    frame_idx   = 0;
    sample_idx  = 0;
    writes_seen = 0;
    load_patterns();
    if (vols.size() < 2 || samples.size() == 0 || exp_addr.size() == 0) begin
      abort_run("pattern file lacks volume, sample or command lines");
    end
    volume = vols[0];
    repeat (reset_cycles) begin
      tick();
      check_value("codec_reset_n", codec_reset_n, 0);
    end
    reset = 1'b0;
    // codec held in reset for the hold time
    repeat (reset_hold - 1) begin
      tick();
      check_value("codec_reset_n", codec_reset_n, 0);
    end
    wait_link(4);
    // one pass of the write list, then change volume well before the next headphone step
    wait_writes(exp_addr.size(), 20 * frame_bits);
    volume = vols[1];
    wait_writes(2 * exp_addr.size(), 20 * frame_bits);
    check_value("headphone data after volume change", last_hp_data, headphone_word(vols[1]));
    $display("All checks passed");
    $finish;
  end

endmodule

// File: sim/ac97_patterns.txt
# vol <hex> : volume, 1f loudest, first at start, second after one pass of writes
# smp <hex> : playback sample, one per frame, list repeats
# cmd <addr hex> <data hex> : expected writes in order, headphone data follows the volume
vol 1c
vol 05
smp a5
smp 3c
smp ff
smp 01
smp 80
smp 7e
smp 00
smp 5a
cmd 04 0000
cmd 18 0808
cmd 1a 0000
cmd 1c 0f0f
cmd 0e 8048
cmd 0a 0000
cmd 20 8000

// File: filelist.f
hdl/ac97_pkg.sv
hdl/ac97_frame_timer.sv
hdl/ac97_frame_tx.sv
hdl/ac97_frame_rx.sv
hdl/ac97_cmd_sequencer.sv
hdl/ac97_codec_link.sv
sim/ac97_link_assertions.sv
sim/ac97_codec_link_tb.sv
